// File: common/zeroheti_pkg.sv
`default_nettype none

package zeroheti_pkg;

  // interrupt controller sizes
  localparam int unsigned NumIrqs   = 8;
  localparam int unsigned IrqWidth  = $clog2(NumIrqs);
  localparam int unsigned NumPrio   = 8;
  localparam int unsigned PrioWidth = $clog2(NumPrio);

  // data memory
  localparam int unsigned DmemWSize  = 256;
  localparam int unsigned DmemAwidth = $clog2(DmemWSize);

  // address map
  localparam logic [31:0] DmemBase  = 32'h0001_0000;
  localparam logic [31:0] DmemLast  = DmemBase + 32'(DmemWSize * 4) - 32'd1;  // 1 KB.
  localparam logic [31:0] HeticBase = 32'h0002_0000;
  localparam logic [31:0] HeticLast = 32'h0002_0FFF;  // 4 KB.
  localparam logic [31:0] ApbBase   = 32'h0003_0000;
  localparam logic [31:0] ApbLast   = 32'h0003_FFFF;

  // register offsets inside the interrupt controller
  localparam logic [11:0] HeticPrioOffs = 12'h000;  // line i at offset + 4*i.
  localparam logic [11:0] HeticEnOffs   = 12'h100;
  localparam logic [11:0] HeticPendOffs = 12'h104;  // write one to clear.

  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } obi_rsp_t;

  typedef struct packed {
    logic [31:0] paddr;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic        psel;
    logic        penable;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    TGT_MEM,
    TGT_HETIC,
    TGT_APB,
    TGT_NONE
  } obi_tgt_e;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

endpackage : zeroheti_pkg

`default_nettype wire

// File: hdl/obi_req_slot.sv
`timescale 1ns/1ps
`default_nettype none

module obi_req_slot (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // manager side
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  zeroheti_pkg::obi_req_t req_i,
  // decoder side
  output logic                   slot_valid_o,
  input  logic                   slot_ready_i,
  output zeroheti_pkg::obi_req_t slot_o
);

  import zeroheti_pkg::*;

  logic     full_q;
  obi_req_t req_q;
  logic     accept;

  // empty, or the held request leaves this cycle.
  assign req_ready_o = ~full_q | slot_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (slot_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  assign slot_valid_o = full_q;
  assign slot_o       = req_q;

endmodule : obi_req_slot

`default_nettype wire

// File: hdl/obi_addr_demux.sv
`timescale 1ns/1ps
`default_nettype none

module obi_addr_demux (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   slot_valid_i,
  output logic                   slot_ready_o,
  input  zeroheti_pkg::obi_req_t slot_i,
  output logic                   mem_issue_o,
  output zeroheti_pkg::obi_req_t mem_req_o,
  input  logic                   mem_done_i,
  input  zeroheti_pkg::obi_rsp_t mem_rsp_i,
  output logic                   hetic_issue_o,
  output zeroheti_pkg::obi_req_t hetic_req_o,
  input  logic                   hetic_done_i,
  input  zeroheti_pkg::obi_rsp_t hetic_rsp_i,
  output logic                   apb_issue_o,
  output zeroheti_pkg::obi_req_t apb_req_o,
  input  logic                   apb_done_i,
  input  zeroheti_pkg::obi_rsp_t apb_rsp_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output zeroheti_pkg::obi_rsp_t rsp_o
);

  import zeroheti_pkg::*;

  obi_tgt_e tgt_d, tgt_q;
  logic     busy_q, none_q, rsp_valid_q;
  logic     take, done;
  obi_rsp_t sel_rsp, rsp_q;

  always_comb begin
    if (slot_i.addr >= DmemBase && slot_i.addr <= DmemLast) begin
      tgt_d = TGT_MEM;
    end else if (slot_i.addr >= HeticBase && slot_i.addr <= HeticLast) begin
      tgt_d = TGT_HETIC;
    end else if (slot_i.addr >= ApbBase && slot_i.addr <= ApbLast) begin
      tgt_d = TGT_APB;
    end else begin
      tgt_d = TGT_NONE;
    end
  end

  // one transaction in flight.
  assign slot_ready_o = ~busy_q;
  assign take         = slot_valid_i & ~busy_q;

  assign mem_issue_o   = take & (tgt_d == TGT_MEM);
  assign hetic_issue_o = take & (tgt_d == TGT_HETIC);
  assign apb_issue_o   = take & (tgt_d == TGT_APB);
  assign mem_req_o     = slot_i;
  assign hetic_req_o   = slot_i;
  assign apb_req_o     = slot_i;

  always_comb begin
    case (tgt_q)
      TGT_MEM:   begin done = mem_done_i;   sel_rsp = mem_rsp_i;   end
      TGT_HETIC: begin done = hetic_done_i; sel_rsp = hetic_rsp_i; end
      TGT_APB:   begin done = apb_done_i;   sel_rsp = apb_rsp_i;   end
      default: begin
        done    = none_q;
        sel_rsp = '{rdata: 32'd0, err: 1'b1};  // unmapped.
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      none_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
      tgt_q       <= TGT_NONE;
    end else begin
      none_q <= take & (tgt_d == TGT_NONE);
      if (take) begin
        busy_q <= 1'b1;
        tgt_q  <= tgt_d;
      end
      if (busy_q && !rsp_valid_q && done) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_valid_q && rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
        busy_q      <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (busy_q && !rsp_valid_q && done) begin
      rsp_q <= sel_rsp;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule : obi_addr_demux

`default_nettype wire

// File: hdl/obi_sram.sv
`timescale 1ns/1ps
`default_nettype none

module obi_sram (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   issue_i,
  input  zeroheti_pkg::obi_req_t req_i,
  output logic                   done_o,
  output zeroheti_pkg::obi_rsp_t rsp_o
);

  import zeroheti_pkg::*;

  logic [31:0]           mem_q [DmemWSize];
  logic [31:0]           rdata_q;
  logic [DmemAwidth-1:0] widx;
  logic                  done_q;

  assign widx = req_i.addr[DmemAwidth+1:2];  // word inside the window.

  always_ff @(posedge clk_i) begin
    if (issue_i && req_i.we) begin
      for (int unsigned b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem_q[widx][8*b+:8] <= req_i.wdata[8*b+:8];
        end
      end
    end
    if (issue_i && !req_i.we) begin
      rdata_q <= mem_q[widx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= issue_i;
    end
  end

  assign done_o = done_q;
  assign rsp_o  = '{rdata: rdata_q, err: 1'b0};

endmodule : obi_sram

`default_nettype wire

// File: hetic/obi_hetic.sv
`timescale 1ns/1ps
`default_nettype none

module obi_hetic (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [zeroheti_pkg::NumIrqs-1:0]    ext_irqs_i,
  // register port
  input  logic                                issue_i,
  input  zeroheti_pkg::obi_req_t              req_i,
  output logic                                done_o,
  output zeroheti_pkg::obi_rsp_t              rsp_o,
  // core side
  output logic                                irq_valid_o,
  output logic [zeroheti_pkg::IrqWidth-1:0]   irq_id_o,
  output logic [zeroheti_pkg::PrioWidth-1:0]  irq_level_o,
  input  logic [zeroheti_pkg::IrqWidth-1:0]   irq_id_i,
  input  logic                                irq_ack_i
);

  import zeroheti_pkg::*;

  logic [PrioWidth-1:0] prio_q [NumIrqs];
  logic [NumIrqs-1:0]   en_q, pend_q, lines_q;
  logic [NumIrqs-1:0]   rise, clr, active;
  logic [9:0]           word, prio_idx;
  logic                 prio_hit, en_hit, pend_hit, wr;
  logic [31:0]          rdata_d, rdata_q;
  logic                 err_d, err_q, done_q;
  logic                 found;
  logic [IrqWidth-1:0]  best_id;
  logic [PrioWidth-1:0] best_prio;

  assign rise   = ext_irqs_i & ~lines_q;
  assign active = pend_q & en_q;

  assign word     = req_i.addr[11:2];
  assign prio_idx = word - HeticPrioOffs[11:2];
  assign prio_hit = prio_idx < 10'(NumIrqs);
  assign en_hit   = word == HeticEnOffs[11:2];
  assign pend_hit = word == HeticPendOffs[11:2];
  assign wr       = issue_i & req_i.we;

  always_comb begin
    clr = '0;
    if (irq_ack_i) begin
      clr[irq_id_i] = 1'b1;  // claimed by the core.
    end
    if (wr && pend_hit) begin
      clr = clr | req_i.wdata[NumIrqs-1:0];
    end
  end

  // highest priority wins, strict compare keeps the lowest id on a tie.
  always_comb begin
    found     = 1'b0;
    best_id   = '0;
    best_prio = '0;
    for (int unsigned i = 0; i < NumIrqs; i++) begin
      if (active[i] && (!found || prio_q[i] > best_prio)) begin
        found     = 1'b1;
        best_id   = IrqWidth'(i);
        best_prio = prio_q[i];
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    if (prio_hit) begin
      rdata_d = 32'(prio_q[prio_idx[IrqWidth-1:0]]);
    end else if (en_hit) begin
      rdata_d = 32'(en_q);
    end else if (pend_hit) begin
      rdata_d = 32'(pend_q);
    end else begin
      err_d = 1'b1;  // undefined offset.
    end
    if (req_i.we) begin
      rdata_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < NumIrqs; i++) begin
        prio_q[i] <= '0;
      end
      en_q    <= '0;
      pend_q  <= '0;
      lines_q <= '0;
      done_q  <= 1'b0;
    end else begin
      lines_q <= ext_irqs_i;
      pend_q  <= (pend_q & ~clr) | rise;
      done_q  <= issue_i;
      if (wr && prio_hit) begin
        prio_q[prio_idx[IrqWidth-1:0]] <= req_i.wdata[PrioWidth-1:0];
      end
      if (wr && en_hit) begin
        en_q <= req_i.wdata[NumIrqs-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  assign done_o      = done_q;
  assign rsp_o       = '{rdata: rdata_q, err: err_q};
  assign irq_valid_o = found;
  assign irq_id_o    = best_id;
  assign irq_level_o = best_prio;

endmodule : obi_hetic

`default_nettype wire

// File: hdl/obi_to_apb.sv
`timescale 1ns/1ps
`default_nettype none

module obi_to_apb (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   issue_i,
  input  zeroheti_pkg::obi_req_t req_i,
  output logic                   done_o,
  output zeroheti_pkg::obi_rsp_t rsp_o,
  output zeroheti_pkg::apb_req_t apb_o,
  input  zeroheti_pkg::apb_rsp_t apb_i
);

  import zeroheti_pkg::*;

  apb_state_e state_q;
  obi_req_t   req_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= APB_IDLE;
    end else begin
      case (state_q)
        APB_IDLE: begin
          if (issue_i) begin
            state_q <= APB_SETUP;
          end
        end
        APB_SETUP: state_q <= APB_ACCESS;
        APB_ACCESS: begin
          if (apb_i.pready) begin
            state_q <= APB_IDLE;
          end
        end
        default: state_q <= APB_IDLE;
      endcase
    end
  end

  // request is held for the whole transfer.
  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      req_q <= req_i;
    end
  end

  always_comb begin
    apb_o.paddr   = req_q.addr;
    apb_o.pwrite  = req_q.we;
    apb_o.pwdata  = req_q.wdata;
    apb_o.pstrb   = req_q.we ? req_q.be : 4'b0000;  // zero on reads.
    apb_o.psel    = state_q != APB_IDLE;
    apb_o.penable = state_q == APB_ACCESS;
  end

  // the decoder registers the response.
  assign done_o = (state_q == APB_ACCESS) & apb_i.pready;
  assign rsp_o  = '{rdata: apb_i.prdata, err: apb_i.pslverr};

endmodule : obi_to_apb

`default_nettype wire

// File: hdl/zeroheti_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module zeroheti_subsys (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // manager port
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  zeroheti_pkg::obi_req_t              req_i,
  output logic                                rsp_valid_o,
  input  logic                                rsp_ready_i,
  output zeroheti_pkg::obi_rsp_t              rsp_o,
  // peripherals
  output zeroheti_pkg::apb_req_t              apb_o,
  input  zeroheti_pkg::apb_rsp_t              apb_i,
  // interrupts
  input  logic [zeroheti_pkg::NumIrqs-1:0]    ext_irqs_i,
  output logic                                irq_valid_o,
  output logic [zeroheti_pkg::IrqWidth-1:0]   irq_id_o,
  output logic [zeroheti_pkg::PrioWidth-1:0]  irq_level_o,
  input  logic [zeroheti_pkg::IrqWidth-1:0]   irq_id_i,
  input  logic                                irq_ack_i
);

  import zeroheti_pkg::*;

  logic     slot_valid, slot_ready;
  obi_req_t slot_req;
  logic     mem_issue, mem_done, hetic_issue, hetic_done, apb_issue, apb_done;
  obi_req_t mem_req, hetic_req, apb_req;
  obi_rsp_t mem_rsp, hetic_rsp, apb_rsp;

  obi_req_slot i_slot (
    .clk_i,
    .rst_n_i,
    .req_valid_i,
    .req_ready_o,
    .req_i,
    .slot_valid_o(slot_valid),
    .slot_ready_i(slot_ready),
    .slot_o      (slot_req)
  );

  obi_addr_demux i_demux (
    .clk_i,
    .rst_n_i,
    .slot_valid_i (slot_valid),
    .slot_ready_o (slot_ready),
    .slot_i       (slot_req),
    .mem_issue_o  (mem_issue),
    .mem_req_o    (mem_req),
    .mem_done_i   (mem_done),
    .mem_rsp_i    (mem_rsp),
    .hetic_issue_o(hetic_issue),
    .hetic_req_o  (hetic_req),
    .hetic_done_i (hetic_done),
    .hetic_rsp_i  (hetic_rsp),
    .apb_issue_o  (apb_issue),
    .apb_req_o    (apb_req),
    .apb_done_i   (apb_done),
    .apb_rsp_i    (apb_rsp),
    .rsp_valid_o,
    .rsp_ready_i,
    .rsp_o
  );

  obi_sram i_dmem (
    .clk_i,
    .rst_n_i,
    .issue_i(mem_issue),
    .req_i  (mem_req),
    .done_o (mem_done),
    .rsp_o  (mem_rsp)
  );

  obi_hetic i_hetic (
    .clk_i,
    .rst_n_i,
    .ext_irqs_i,
    .issue_i(hetic_issue),
    .req_i  (hetic_req),
    .done_o (hetic_done),
    .rsp_o  (hetic_rsp),
    .irq_valid_o,
    .irq_id_o,
    .irq_level_o,
    .irq_id_i,
    .irq_ack_i
  );

  obi_to_apb i_obi_to_apb (
    .clk_i,
    .rst_n_i,
    .issue_i(apb_issue),
    .req_i  (apb_req),
    .done_o (apb_done),
    .rsp_o  (apb_rsp),
    .apb_o,
    .apb_i
  );

endmodule : zeroheti_subsys

`default_nettype wire

// File: tests/zeroheti_checker.sv
`timescale 1ns/1ps
`default_nettype none

module zeroheti_checker (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   rsp_valid_i,
  input logic                   rsp_ready_i,
  input zeroheti_pkg::obi_rsp_t rsp_i,
  input zeroheti_pkg::apb_req_t apb_req_i,
  input zeroheti_pkg::apb_rsp_t apb_rsp_i,
  input logic                   irq_valid_i
);

  rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else $error("response dropped or changed while held");

  psel_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    apb_req_i.psel && !(apb_req_i.penable && apb_rsp_i.pready) |=> apb_req_i.psel)
    else $error("psel fell before pready");

  // access phase follows a setup cycle.
  penable_after_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(apb_req_i.penable) |-> $past(apb_req_i.psel) && apb_req_i.psel)
    else $error("penable rose without a setup cycle");

  irq_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> !irq_valid_i)
    else $error("irq_valid_o high after reset");

endmodule : zeroheti_checker

bind zeroheti_subsys zeroheti_checker i_checker (
  .clk_i,
  .rst_n_i,
  .rsp_valid_i(rsp_valid_o),
  .rsp_ready_i,
  .rsp_i      (rsp_o),
  .apb_req_i  (apb_o),
  .apb_rsp_i  (apb_i),
  .irq_valid_i(irq_valid_o)
);

`default_nettype wire

// File: tests/zeroheti_tb.sv
`timescale 1ns/1ps
`default_nettype none

module zeroheti_tb;

  import zeroheti_pkg::*;

  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [31:0] rdata;  // expected, compared on reads only.
    logic        err;
  } txn_t;

  logic                 clk_i, rst_n_i;
  logic                 req_valid_i, req_ready_o, rsp_valid_o, rsp_ready_i;
  obi_req_t             req_i;
  obi_rsp_t             rsp_o;
  apb_req_t             apb_o;
  apb_rsp_t             apb_i;
  logic [NumIrqs-1:0]   ext_irqs_i;
  logic                 irq_valid_o, irq_ack_i;
  logic [IrqWidth-1:0]  irq_id_o, irq_id_i;
  logic [PrioWidth-1:0] irq_level_o;

  txn_t                 txns [22];
  logic [IrqWidth-1:0]  exp_ids [4];
  logic [PrioWidth-1:0] exp_levels [4];
  logic [31:0]          apb_mem [64];
  int unsigned          apb_wait, apb_pick, rsp_cnt, err_cnt;
  logic                 apb_bad;

  zeroheti_subsys dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // 40 cycles per table entry, plus reset and the interrupt phase.
  initial begin
    repeat ($size(txns) * 40 + 60) @(posedge clk_i);
    $display("Timeout: the run did not complete in the expected number of cycles");
    $display("Something failed");
    $finish;
  end

  task automatic answer_apb();
    apb_i.pready  <= 1'b1;
    apb_i.pslverr <= apb_bad;
    apb_i.prdata  <= (apb_bad || apb_o.pwrite) ? 32'h0 : apb_mem[apb_o.paddr[7:2]];
  endtask

  // peripheral model with 0 to 3 random wait states.
  always @(posedge clk_i) begin
    apb_bad = apb_o.paddr > ApbBase + 32'h100;
    if (!rst_n_i) begin
      apb_i    <= '0;
      apb_wait <= 0;
    end else if (apb_o.psel && !apb_o.penable) begin
      apb_pick = $urandom % 4;
      apb_wait <= apb_pick;
      if (apb_pick == 0) answer_apb();
    end else if (apb_o.psel && !apb_i.pready) begin
      apb_wait <= apb_wait - 1;
      if (apb_wait == 1) answer_apb();
    end else if (apb_o.psel) begin
      apb_i <= '0;  // transfer completes on this edge.
      if (apb_o.pwrite && !apb_bad) begin
        for (int b = 0; b < 4; b++) begin
          if (apb_o.pstrb[b]) apb_mem[apb_o.paddr[7:2]][8*b+:8] <= apb_o.pwdata[8*b+:8];
        end
      end
    end
  end

  // counts every response handshake on the manager port.
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_cnt <= 0;
    end else if (rsp_valid_o && rsp_ready_i) begin
      rsp_cnt <= rsp_cnt + 1;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    err_cnt++;
    $display("Error at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, got);
  endtask

  task automatic send_requests();
    for (int i = 0; i < $size(txns); i++) begin
      req_valid_i <= 1'b1;
      req_i <= '{addr: txns[i].addr, we: txns[i].we, be: txns[i].be, wdata: txns[i].wdata};
      do begin
        @(posedge clk_i);
      end while (!req_ready_o);
    end
    req_valid_i <= 1'b0;
  endtask

  task automatic collect_responses();
    logic got;
    rsp_ready_i <= ($urandom % 3) != 0;
    for (int i = 0; i < $size(txns); i++) begin
      do begin
        @(posedge clk_i);
        got = rsp_valid_o && rsp_ready_i;
        if (!got) rsp_ready_i <= ($urandom % 3) != 0;
      end while (!got);
      assert (rsp_o.err == txns[i].err)
        else report_mismatch("rsp_o.err", 32'(txns[i].err), 32'(rsp_o.err));
      if (!txns[i].we) begin
        assert (rsp_o.rdata == txns[i].rdata)
          else report_mismatch("rsp_o.rdata", txns[i].rdata, rsp_o.rdata);
      end
      rsp_ready_i <= ($urandom % 3) != 0;
    end
  endtask

  task automatic run_irq_phase();
    ext_irqs_i <= 8'b1101_0110;  // lines 1, 2, 4, 6 and 7.
    for (int k = 0; k < 4; k++) begin
      do begin
        @(posedge clk_i);
      end while (!irq_valid_o);
      assert (irq_id_o == exp_ids[k])
        else report_mismatch("irq_id_o", 32'(exp_ids[k]), 32'(irq_id_o));
      assert (irq_level_o == exp_levels[k])
        else report_mismatch("irq_level_o", 32'(exp_levels[k]), 32'(irq_level_o));
      irq_id_i  <= exp_ids[k];
      irq_ack_i <= 1'b1;
      @(posedge clk_i);
      irq_ack_i <= 1'b0;
    end
    @(posedge clk_i);
    assert (!irq_valid_o) else begin
      err_cnt++;
      $display("Error at %0t ns: an interrupt is still reported after the last ack", $time);
    end
  endtask

  initial begin
    void'($urandom(38488));
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    apb_i       = '0;
    ext_irqs_i  = '0;
    irq_id_i    = '0;
    irq_ack_i   = 1'b0;
    err_cnt     = 0;
    // kind (we), address, write data, byte enables, expected read data, expected error
    txns = '{
      '{1'b1, 32'h0001_0000, 32'h1122_3344, 4'hF, 32'h0000_0000, 1'b0},
      '{1'b1, 32'h0001_03FC, 32'hDEAD_BEEF, 4'hF, 32'h0000_0000, 1'b0},
      '{1'b0, 32'h0001_0000, 32'h0000_0000, 4'hF, 32'h1122_3344, 1'b0},
      '{1'b0, 32'h0001_03FC, 32'h0000_0000, 4'hF, 32'hDEAD_BEEF, 1'b0},
      '{1'b1, 32'h0001_0000, 32'hFFEE_DDCC, 4'h5, 32'h0000_0000, 1'b0},
      '{1'b0, 32'h0001_0000, 32'h0000_0000, 4'hF, 32'h11EE_33CC, 1'b0},
      '{1'b1, 32'h0003_0010, 32'hCAFE_0001, 4'hF, 32'h0000_0000, 1'b0},
      '{1'b1, 32'h0003_0020, 32'h0BAD_F00D, 4'hF, 32'h0000_0000, 1'b0},
      '{1'b0, 32'h0003_0010, 32'h0000_0000, 4'hF, 32'hCAFE_0001, 1'b0},
      '{1'b0, 32'h0003_0020, 32'h0000_0000, 4'hF, 32'h0BAD_F00D, 1'b0},
      '{1'b0, 32'h0003_0200, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b1},
      '{1'b0, 32'h0000_1000, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b1},
      '{1'b1, 32'h0005_0000, 32'h1234_5678, 4'hF, 32'h0000_0000, 1'b1},
      '{1'b1, 32'h0002_0004, 32'h0000_0003, 4'hF, 32'h0000_0000, 1'b0},
      '{1'b1, 32'h0002_0008, 32'h0000_0005, 4'hF, 32'h0000_0000, 1'b0},
      '{1'b1, 32'h0002_0010, 32'h0000_0005, 4'hF, 32'h0000_0000, 1'b0},
      '{1'b1, 32'h0002_0018, 32'h0000_0002, 4'hF, 32'h0000_0000, 1'b0},
      '{1'b1, 32'h0002_001C, 32'h0000_0007, 4'hF, 32'h0000_0000, 1'b0},
      '{1'b0, 32'h0002_0008, 32'h0000_0000, 4'hF, 32'h0000_0005, 1'b0},
      '{1'b1, 32'h0002_0100, 32'h0000_0056, 4'hF, 32'h0000_0000, 1'b0},
      '{1'b0, 32'h0002_0100, 32'h0000_0000, 4'hF, 32'h0000_0056, 1'b0},
      '{1'b0, 32'h0002_0200, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b1}
    };
    // line 7 has the top priority but stays disabled.
    exp_ids    = '{3'd2, 3'd4, 3'd1, 3'd6};
    exp_levels = '{3'd5, 3'd5, 3'd3, 3'd2};
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    fork
      send_requests();
      collect_responses();
    join
    repeat (4) @(posedge clk_i);
    assert (!rsp_valid_o && rsp_cnt == $size(txns)) else begin
      err_cnt++;
      $display("Error at %0t ns: a response was lost or duplicated", $time);
    end
    run_irq_phase();
    $display("responses %0d of %0d, errors %0d", rsp_cnt, $size(txns), err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : zeroheti_tb

`default_nettype wire

// File: vlog.f
common/zeroheti_pkg.sv
hdl/obi_req_slot.sv
hdl/obi_addr_demux.sv
hdl/obi_sram.sv
hetic/obi_hetic.sv
hdl/obi_to_apb.sv
hdl/zeroheti_subsys.sv
tests/zeroheti_checker.sv
tests/zeroheti_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the output for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module zeroheti_tb -f vlog.f -o zeroheti_sim \
  && ./obj_dir/zeroheti_sim | tee /dev/stderr | grep -q "^Everything OK$" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
